// File: hk_config.svh
`ifndef HK_CONFIG_SVH
`define HK_CONFIG_SVH

//////////////////////////////////////////////////
// widths and counts
//////////////////////////////////////////////////

`define HK_DWL          8             // led width
`define HK_DWE          8             // expansion gpio bank width
`define HK_NUM_BANKS    2             // bank 0 is p row, bank 1 is n row
`define HK_DNA_BITS     57            // device dna length
`define HK_DNA_CLK_DIV  8             // system clocks per dna clock
`define HK_ADDR_BITS    20            // decoded part of bus address

// board release 1
`define HK_ID_VALUE     32'h0000_0001

//////////////////////////////////////////////////
// register map, byte offsets
//////////////////////////////////////////////////

`define HK_REG_ID       20'h00000
`define HK_REG_DNA_LO   20'h00004
`define HK_REG_DNA_HI   20'h00008
`define HK_REG_CFG      20'h0000C     // bit 0 digital loop
`define HK_REG_OE_BASE  20'h00010     // + 4*bank
`define HK_REG_OUT_BASE 20'h00018     // + 4*bank
`define HK_REG_IN_BASE  20'h00020     // + 4*bank
`define HK_REG_STATUS   20'h00028     // bit 0 dna done
`define HK_REG_LED      20'h00030

`endif

// File: hk_pkg.sv
`default_nettype none

`include "hk_config.svh"

package hk_pkg;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  // master side, strobes are single cycle
  typedef struct packed {
    logic                     wen;
    logic                     ren;
    logic [`HK_ADDR_BITS-1:0] addr;
    logic [31:0]              wdata;
  } hk_bus_req_t;

  // slave side, ack one cycle after strobe
  typedef struct packed {
    logic        ack;
    logic        err;    // high while in reset
    logic [31:0] rdata;
  } hk_bus_rsp_t;

  //////////////////////////////////////////////////
  // gpio bank
  //////////////////////////////////////////////////

  typedef struct packed {
    logic               oe_we;   // write strobe, oe reg
    logic               out_we;  // write strobe, out reg
    logic [`HK_DWE-1:0] data;    // wdata cut to bank width
  } hk_bank_wr_t;

  typedef struct packed {
    logic [`HK_DWE-1:0] oe;
    logic [`HK_DWE-1:0] out;
    logic [`HK_DWE-1:0] in;      // sampled pins
  } hk_bank_st_t;

  // dna readout sequence
  typedef enum logic [1:0] {
    DNA_LOAD,
    DNA_SHIFT,
    DNA_DONE
  } hk_dna_state_e;

endpackage

`default_nettype wire

// File: hk_dna_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module hk_dna_reader (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    dna_dout_i,   // serial data, msb first
  output logic                    dna_clk_o,    // slow dna clock
  output logic                    dna_read_o,   // load request
  output logic                    dna_shift_o,  // shift enable
  output logic [`HK_DNA_BITS-1:0] dna_value_o,
  output logic                    dna_done_o
);

  localparam int DIV_W = $clog2(`HK_DNA_CLK_DIV);
  localparam int BIT_W = $clog2(`HK_DNA_BITS);

  // dna clock rises after RISE_CNT, falls after LAST_CNT
  localparam logic [DIV_W-1:0] RISE_CNT = DIV_W'(`HK_DNA_CLK_DIV / 2 - 1);
  localparam logic [DIV_W-1:0] LAST_CNT = DIV_W'(`HK_DNA_CLK_DIV - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`HK_DNA_BITS - 1);

  hk_pkg::hk_dna_state_e state;
  logic [DIV_W-1:0]      div_cnt;   // position inside one dna period
  logic [BIT_W-1:0]      bit_cnt;   // bits shifted so far
  logic                  rise_next; // last cycle before rising dna_clk
  logic                  period_end;

  assign rise_next  = (div_cnt == RISE_CNT);
  assign period_end = (div_cnt == LAST_CNT);

  //////////////////////////////////////////////////
  // sequencer and clock divider
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= hk_pkg::DNA_LOAD;
      div_cnt     <= '0;
      bit_cnt     <= '0;
      dna_clk_o   <= 1'b0;
      dna_read_o  <= 1'b0;
      dna_shift_o <= 1'b0;
    end else begin
      dna_read_o  <= (state == hk_pkg::DNA_LOAD);
      dna_shift_o <= (state == hk_pkg::DNA_SHIFT);
      if (state != hk_pkg::DNA_DONE) begin  // clock stops once done
        div_cnt <= period_end ? '0 : div_cnt + 1'b1;
        if (rise_next)
          dna_clk_o <= 1'b1;
        else if (period_end)
          dna_clk_o <= 1'b0;
      end
      if (period_end) begin
        case (state)
          hk_pkg::DNA_LOAD: state <= hk_pkg::DNA_SHIFT;  // one period of load
          hk_pkg::DNA_SHIFT: begin
            if (bit_cnt == LAST_BIT)
              state <= hk_pkg::DNA_DONE;
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          default: state <= hk_pkg::DNA_DONE;
        endcase
      end
    end
  end

  // capture just before each rising edge, device shifts on that edge
  always_ff @(posedge clk) begin
    if (state == hk_pkg::DNA_SHIFT && rise_next)
      dna_value_o <= {dna_value_o[`HK_DNA_BITS-2:0], dna_dout_i};
  end

  assign dna_done_o = (state == hk_pkg::DNA_DONE);

endmodule

`default_nettype wire

// File: hk_write_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module hk_write_ctrl (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  hk_pkg::hk_bus_req_t                     bus_req_i,
  output hk_pkg::hk_bank_wr_t [`HK_NUM_BANKS-1:0] bank_wr_o,
  output logic                [`HK_DWL-1:0]       led_o,
  output logic                                    digital_loop_o
);

  logic led_hit;   // write to led reg
  logic cfg_hit;   // write to config reg

  assign led_hit = bus_req_i.wen && (bus_req_i.addr == `HK_REG_LED);
  assign cfg_hit = bus_req_i.wen && (bus_req_i.addr == `HK_REG_CFG);

  //////////////////////////////////////////////////
  // local registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;
    end else begin
      if (led_hit)
        led_o <= bus_req_i.wdata[`HK_DWL-1:0];  // upper bits dropped
      if (cfg_hit)
        digital_loop_o <= bus_req_i.wdata[0];
    end
  end

  //////////////////////////////////////////////////
  // per bank strobes
  //////////////////////////////////////////////////

  // bank registers update on the same edge as the strobe
  for (genvar b = 0; b < `HK_NUM_BANKS; b++) begin : g_bank_dec
    localparam logic [`HK_ADDR_BITS-1:0] OE_ADDR  =
      `HK_ADDR_BITS'(`HK_REG_OE_BASE + 4 * b);
    localparam logic [`HK_ADDR_BITS-1:0] OUT_ADDR =
      `HK_ADDR_BITS'(`HK_REG_OUT_BASE + 4 * b);

    assign bank_wr_o[b].oe_we  = bus_req_i.wen && (bus_req_i.addr == OE_ADDR);
    assign bank_wr_o[b].out_we = bus_req_i.wen && (bus_req_i.addr == OUT_ADDR);
    assign bank_wr_o[b].data   = bus_req_i.wdata[`HK_DWE-1:0];  // same for all banks
  end

endmodule

`default_nettype wire

// File: hk_gpio_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module hk_gpio_bank (
  input  logic                clk,
  input  logic                rstn,
  input  hk_pkg::hk_bank_wr_t wr_i,   // strobes from write ctrl
  input  logic [`HK_DWE-1:0]  pin_i,  // connector inputs
  output hk_pkg::hk_bank_st_t st_o
);

  logic [`HK_DWE-1:0] oe_q;    // output enable per pin
  logic [`HK_DWE-1:0] out_q;   // output value per pin
  logic [`HK_DWE-1:0] in_q;    // input sample

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      oe_q  <= '0;   // all pins tristated
      out_q <= '0;
    end else begin
      if (wr_i.oe_we)
        oe_q <= wr_i.data;
      if (wr_i.out_we)
        out_q <= wr_i.data;
    end
  end

  // one sample stage on the inputs
  always_ff @(posedge clk) begin
    in_q <= pin_i;
  end

  assign st_o.oe  = oe_q;
  assign st_o.out = out_q;
  assign st_o.in  = in_q;

endmodule

`default_nettype wire

// File: hk_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module hk_read_mux (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  hk_pkg::hk_bus_req_t                     bus_req_i,
  input  hk_pkg::hk_bank_st_t [`HK_NUM_BANKS-1:0] bank_st_i,
  input  logic                [`HK_DNA_BITS-1:0]  dna_value_i,
  input  logic                                    dna_done_i,
  input  logic                [`HK_DWL-1:0]       led_i,
  input  logic                                    digital_loop_i,
  output hk_pkg::hk_bus_rsp_t                     bus_rsp_o
);

  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;
  logic [31:0] rdata_nxt;  // selected read word

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  always_comb begin
    rdata_nxt = '0;  // unmapped reads zero
    case (bus_req_i.addr)
      `HK_REG_ID:     rdata_nxt = `HK_ID_VALUE;
      `HK_REG_DNA_LO: rdata_nxt = dna_value_i[31:0];
      `HK_REG_DNA_HI: rdata_nxt = 32'(dna_value_i[`HK_DNA_BITS-1:32]);  // 25 bits
      `HK_REG_CFG:    rdata_nxt = 32'(digital_loop_i);
      `HK_REG_STATUS: rdata_nxt = 32'(dna_done_i);
      `HK_REG_LED:    rdata_nxt = 32'(led_i);
      default:        rdata_nxt = '0;
    endcase
    // bank registers, base + 4*b
    for (int b = 0; b < `HK_NUM_BANKS; b++) begin
      if (bus_req_i.addr == `HK_ADDR_BITS'(`HK_REG_OE_BASE + 4 * b))
        rdata_nxt = 32'(bank_st_i[b].oe);
      if (bus_req_i.addr == `HK_ADDR_BITS'(`HK_REG_OUT_BASE + 4 * b))
        rdata_nxt = 32'(bank_st_i[b].out);
      if (bus_req_i.addr == `HK_ADDR_BITS'(`HK_REG_IN_BASE + 4 * b))
        rdata_nxt = 32'(bank_st_i[b].in);  // already one cycle old
    end
  end

  //////////////////////////////////////////////////
  // response registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack_q <= 1'b0;
      err_q <= 1'b1;  // flag slave not ready
    end else begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;  // every access acked next cycle
      err_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= rdata_nxt;
  end

  assign bus_rsp_o.ack   = ack_q;
  assign bus_rsp_o.err   = err_q;
  assign bus_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: housekeeping_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module housekeeping_top (
  input  logic                clk,
  input  logic                rstn,
  // system bus
  input  hk_pkg::hk_bus_req_t bus_req_i,
  output hk_pkg::hk_bus_rsp_t bus_rsp_o,
  // board outputs
  output logic [`HK_DWL-1:0]  led_o,
  output logic                digital_loop_o,
  // expansion connector, p row
  input  logic [`HK_DWE-1:0]  exp_p_i,
  output logic [`HK_DWE-1:0]  exp_p_o,
  output logic [`HK_DWE-1:0]  exp_p_oe_o,
  // expansion connector, n row
  input  logic [`HK_DWE-1:0]  exp_n_i,
  output logic [`HK_DWE-1:0]  exp_n_o,
  output logic [`HK_DWE-1:0]  exp_n_oe_o,
  // dna device pins
  input  logic                dna_dout_i,
  output logic                dna_clk_o,
  output logic                dna_read_o,
  output logic                dna_shift_o
);

  hk_pkg::hk_bank_wr_t [`HK_NUM_BANKS-1:0] bank_wr;
  hk_pkg::hk_bank_st_t [`HK_NUM_BANKS-1:0] bank_st;
  logic [`HK_NUM_BANKS-1:0][`HK_DWE-1:0]   exp_in;   // pins per bank
  logic [`HK_DNA_BITS-1:0]                 dna_value;
  logic                                    dna_done;

  //////////////////////////////////////////////////
  // dna readout
  //////////////////////////////////////////////////

  hk_dna_reader u_dna (
    .clk         (clk),
    .rstn        (rstn),
    .dna_dout_i  (dna_dout_i),
    .dna_clk_o   (dna_clk_o),
    .dna_read_o  (dna_read_o),
    .dna_shift_o (dna_shift_o),
    .dna_value_o (dna_value),
    .dna_done_o  (dna_done)
  );

  //////////////////////////////////////////////////
  // write side and gpio banks
  //////////////////////////////////////////////////

  hk_write_ctrl u_wr (
    .clk            (clk),
    .rstn           (rstn),
    .bus_req_i      (bus_req_i),
    .bank_wr_o      (bank_wr),
    .led_o          (led_o),
    .digital_loop_o (digital_loop_o)
  );

  // bank 0 p row, bank 1 n row
  assign exp_in[0] = exp_p_i;
  assign exp_in[1] = exp_n_i;

  for (genvar b = 0; b < `HK_NUM_BANKS; b++) begin : g_bank
    hk_gpio_bank u_bank (
      .clk   (clk),
      .rstn  (rstn),
      .wr_i  (bank_wr[b]),
      .pin_i (exp_in[b]),
      .st_o  (bank_st[b])
    );
  end

  assign exp_p_o    = bank_st[0].out;
  assign exp_p_oe_o = bank_st[0].oe;
  assign exp_n_o    = bank_st[1].out;
  assign exp_n_oe_o = bank_st[1].oe;

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  hk_read_mux u_rd (
    .clk            (clk),
    .rstn           (rstn),
    .bus_req_i      (bus_req_i),
    .bank_st_i      (bank_st),
    .dna_value_i    (dna_value),
    .dna_done_i     (dna_done),
    .led_i          (led_o),
    .digital_loop_i (digital_loop_o),
    .bus_rsp_o      (bus_rsp_o)
  );

endmodule

`default_nettype wire

// File: tb_housekeeping.sv
`timescale 1ns/10ps
`default_nettype none

`include "hk_config.svh"

module tb_housekeeping;

  localparam int ACK_LIMIT  = 8;     // cycles to wait for ack
  localparam int POLL_LIMIT = 400;   // status reads before giving up

  logic                    clk;
  logic                    rstn;
  hk_pkg::hk_bus_req_t     bus_req;
  hk_pkg::hk_bus_rsp_t     bus_rsp;
  logic [`HK_DWL-1:0]      led;
  logic                    loop;
  logic [`HK_DWE-1:0]      p_in;
  logic [`HK_DWE-1:0]      p_out;
  logic [`HK_DWE-1:0]      p_oe;
  logic [`HK_DWE-1:0]      n_in;
  logic [`HK_DWE-1:0]      n_out;
  logic [`HK_DWE-1:0]      n_oe;
  logic                    dna_dout = 1'b0;
  logic                    dna_clk;
  logic                    dna_read;
  logic                    dna_shift;

  integer                  seed;
  logic [`HK_DNA_BITS-1:0] dna_const;          // value held by the device
  logic [`HK_DNA_BITS-1:0] dna_sr = '0;        // device shift register
  logic                    strobe_q = 1'b0;    // strobe seen at last rising edge
  logic                    mon_en = 1'b0;
  logic [`HK_DWL-1:0]      exp_led;
  logic                    exp_loop;
  logic [`HK_DWE-1:0]      exp_oe [`HK_NUM_BANKS];
  logic [`HK_DWE-1:0]      exp_out [`HK_NUM_BANKS];

  housekeeping_top UUT (
    .clk            (clk),
    .rstn           (rstn),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .led_o          (led),
    .digital_loop_o (loop),
    .exp_p_i        (p_in),
    .exp_p_o        (p_out),
    .exp_p_oe_o     (p_oe),
    .exp_n_i        (n_in),
    .exp_n_o        (n_out),
    .exp_n_oe_o     (n_oe),
    .dna_dout_i     (dna_dout),
    .dna_clk_o      (dna_clk),
    .dna_read_o     (dna_read),
    .dna_shift_o    (dna_shift)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  //////////////////////////////////////////////////
  // dna device model and ack monitor
  //////////////////////////////////////////////////

  always @(posedge dna_clk) begin
    if (dna_read)
      dna_sr <= dna_const;                               // load
    else if (dna_shift)
      dna_sr <= {dna_sr[`HK_DNA_BITS-2:0], 1'b0};        // next bit up
  end

  always @(negedge clk) dna_dout <= dna_sr[`HK_DNA_BITS-1];  // msb on the pin

  always @(posedge clk) strobe_q <= rstn && (bus_req.wen || bus_req.ren);

  // ack only in the cycle after a strobe
  always @(negedge clk) begin
    if (mon_en) begin
      compare("bus_rsp.ack", 32'(bus_rsp.ack), 32'(strobe_q));
      compare("bus_rsp.err", 32'(bus_rsp.err), 32'd0);
    end
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0d ns while waiting for %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // starts and ends on a falling edge
  task automatic bus_access(input logic wr, input logic [`HK_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    bus_req.wen   = wr;
    bus_req.ren   = !wr;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    @(negedge clk);
    bus_req.wen = 1'b0;
    bus_req.ren = 1'b0;
    waited = 0;
    while (!bus_rsp.ack) begin
      if (waited == ACK_LIMIT)
        give_up("bus ack");
      @(negedge clk);
      waited++;
    end
    compare("ack delay", 32'(waited), 32'd0);  // ack in first cycle after strobe
    rdata = bus_rsp.rdata;
    @(negedge clk);                            // idle gap
  endtask

  task automatic bus_write(input logic [`HK_ADDR_BITS-1:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic bus_read(input logic [`HK_ADDR_BITS-1:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'd0, data);
  endtask

  // ports and readback against the expected register image
  task automatic check_regs;
    logic [31:0] rd;
    int          b;
    compare("led_o", 32'(led), 32'(exp_led));
    compare("digital_loop_o", 32'(loop), 32'(exp_loop));
    compare("exp_p_oe_o", 32'(p_oe), 32'(exp_oe[0]));
    compare("exp_p_o", 32'(p_out), 32'(exp_out[0]));
    compare("exp_n_oe_o", 32'(n_oe), 32'(exp_oe[1]));
    compare("exp_n_o", 32'(n_out), 32'(exp_out[1]));
    bus_read(`HK_REG_ID, rd);
    compare("ID", rd, `HK_ID_VALUE);
    bus_read(`HK_REG_LED, rd);
    compare("LED", rd, 32'(exp_led));
    bus_read(`HK_REG_CFG, rd);
    compare("CFG", rd, 32'(exp_loop));
    for (b = 0; b < `HK_NUM_BANKS; b++) begin
      bus_read(`HK_REG_OE_BASE + 20'(4 * b), rd);
      compare("OE", rd, 32'(exp_oe[b]));
      bus_read(`HK_REG_OUT_BASE + 20'(4 * b), rd);
      compare("OUT", rd, 32'(exp_out[b]));
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset_id;
    int b;
    exp_led  = '0;
    exp_loop = 1'b0;
    for (b = 0; b < `HK_NUM_BANKS; b++) begin
      exp_oe[b]  = '0;
      exp_out[b] = '0;
    end
    compare("bus_rsp.err", 32'(bus_rsp.err), 32'd0);
    check_regs;
  endtask

  task automatic test_dna;
    logic [31:0] rd;
    int          polls;
    polls = 0;
    rd    = '0;
    while (!rd[0]) begin                   // poll done flag
      if (polls == POLL_LIMIT)
        give_up("DNA done flag");
      bus_read(`HK_REG_STATUS, rd);
      polls++;
    end
    compare("STATUS", rd, 32'd1);
    bus_read(`HK_REG_DNA_LO, rd);
    compare("DNA_LO", rd, dna_const[31:0]);
    bus_read(`HK_REG_DNA_HI, rd);
    compare("DNA_HI", rd, 32'(dna_const[`HK_DNA_BITS-1:32]));  // upper 25 bits zero extended
    compare("dna_clk_o", 32'(dna_clk), 32'd0);                  // clock stopped
  endtask

  task automatic test_write_readback;
    logic [31:0] val;
    int          b;
    val     = $random(seed);
    exp_led = val[`HK_DWL-1:0];
    bus_write(`HK_REG_LED, val);
    check_regs;
    val      = $random(seed) | 32'h1;      // loop bit set
    exp_loop = 1'b1;
    bus_write(`HK_REG_CFG, val);
    check_regs;
    for (b = 0; b < `HK_NUM_BANKS; b++) begin
      val       = $random(seed);
      exp_oe[b] = val[`HK_DWE-1:0];
      bus_write(`HK_REG_OE_BASE + 20'(4 * b), val);
      check_regs;
      val        = $random(seed);
      exp_out[b] = val[`HK_DWE-1:0];
      bus_write(`HK_REG_OUT_BASE + 20'(4 * b), val);
      check_regs;
    end
  endtask

  task automatic test_inputs;
    logic [31:0] rd;
    logic [31:0] val;
    val  = $random(seed);
    p_in = val[`HK_DWE-1:0];
    n_in = val[2*`HK_DWE-1:`HK_DWE];
    @(negedge clk);
    @(negedge clk);
    bus_read(`HK_REG_IN_BASE, rd);
    compare("IN p row", rd, 32'(p_in));
    bus_read(`HK_REG_IN_BASE + 20'd4, rd);
    compare("IN n row", rd, 32'(n_in));
  endtask

  task automatic test_unmapped;
    logic [31:0] rd;
    bus_write(`HK_REG_ID, $random(seed));
    bus_write(`HK_REG_DNA_LO, $random(seed));  // read only
    bus_write(20'h00034, $random(seed));
    bus_write(20'h80030, $random(seed));       // led offset with high bits set
    check_regs;
    bus_read(`HK_REG_DNA_LO, rd);
    compare("DNA_LO", rd, dna_const[31:0]);
    bus_read(20'h00034, rd);
    compare("unused 0x00034", rd, 32'd0);
    bus_read(20'h80030, rd);
    compare("unused 0x80030", rd, 32'd0);
  endtask

  // two reads on consecutive cycles
  task automatic test_ack_timing;
    bus_req.ren  = 1'b1;
    bus_req.addr = `HK_REG_ID;
    @(negedge clk);
    bus_req.addr = `HK_REG_LED;
    compare("bus_rsp.ack", 32'(bus_rsp.ack), 32'd1);
    compare("bus_rsp.rdata", bus_rsp.rdata, `HK_ID_VALUE);
    @(negedge clk);
    bus_req.ren = 1'b0;
    compare("bus_rsp.ack", 32'(bus_rsp.ack), 32'd1);
    compare("bus_rsp.rdata", bus_rsp.rdata, 32'(exp_led));
    repeat (4) begin
      @(negedge clk);
      compare("bus_rsp.ack", 32'(bus_rsp.ack), 32'd0);
    end
  endtask

  initial begin
    seed      = 32'ha4bb8dfb;
    dna_const = `HK_DNA_BITS'({$random(seed), $random(seed)});
    rstn      = 1'b0;
    bus_req   = '0;
    p_in      = '0;
    n_in      = '0;
    repeat (3) @(posedge clk);             // reset for 3 cycles
    @(negedge clk);
    compare("bus_rsp.err", 32'(bus_rsp.err), 32'd1);
    compare("bus_rsp.ack", 32'(bus_rsp.ack), 32'd0);
    compare("dna pins", {29'd0, dna_clk, dna_read, dna_shift}, 32'd0);
    rstn = 1'b1;
    @(negedge clk);
    mon_en = 1'b1;
    test_reset_id;
    test_dna;
    test_write_readback;
    test_inputs;
    test_unmapped;
    test_ack_timing;
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: housekeeping.f
+incdir+.
hk_pkg.sv
hk_dna_reader.sv
hk_write_ctrl.sv
hk_gpio_bank.sv
hk_read_mux.sv
housekeeping_top.sv
tb_housekeeping.sv

// File: run_sim.sh
#!/bin/sh
# build and run the housekeeping testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_housekeeping \
  -f housekeeping.f -o tb_housekeeping
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_housekeeping > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
